/* files.f */
+incdir+verification
source/ntt_pkg.sv
source/word_collector.sv
source/butterfly_unit.sv
source/ntt_engine.sv
source/coefficient_sender.sv
source/ntt_top.sv
verification/ntt_checker.sv
verification/ntt_tb.sv

/* source/butterfly_unit.sv */
`timescale 1ns/100ps

module butterfly_unit
    import ntt_pkg::*;
(
    input  lane_pair_t operands,
    output coeff_t     upper_out,
    output coeff_t     lower_out
);

    logic [29:0] prod;
    logic [15:0] m_fac;
    logic [31:0] red_sum;
    logic [15:0] z_val;
    coeff_t      t_val;
    logic [16:0] add_sum;

    // montgomery product lower * twiddle * 2^-16
    assign prod    = 30'(operands.lower) * 30'(operands.twiddle);
    assign m_fac   = prod[15:0] * q_neg_inv;
    // low half is zero by construction of m_fac
    assign red_sum = 32'(prod) + 32'(m_fac) * 32'(q_mod);
    assign z_val   = red_sum[31:16];

    // z below 2q, one subtract is enough
    assign t_val = (z_val >= 16'(q_mod)) ? z_val - 16'(q_mod) : z_val;

    // ------------------------------------------------------------------
    // modular add and subtract
    // ------------------------------------------------------------------
    assign add_sum = 17'(operands.upper) + 17'(t_val);

    assign upper_out = (add_sum >= 17'(q_mod)) ? coeff_t'(add_sum - 17'(q_mod))
                                               : coeff_t'(add_sum);

    assign lower_out = (operands.upper >= t_val) ? operands.upper - t_val
                                                 : operands.upper + 16'(q_mod) - t_val;

endmodule

/* source/coefficient_sender.sv */
`timescale 1ns/100ps

module coefficient_sender
    import ntt_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       done,
    output coeff_idx_t rd_idx,
    input  coeff_t     rd_coeff,
    output logic       out_req,
    output coeff_t     out_coeff,
    input  logic       out_ack,
    output logic       sent
);

    localparam coeff_idx_t last_idx = coeff_idx_t'(n_coeff - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_wait_ack,
        st_wait_release
    } state_t;

    state_t     state;
    coeff_idx_t idx;

    assign rd_idx = idx;

    // ------------------------------------------------------------------
    // four-phase sender, indices 0 to 127
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            idx       <= '0;
            out_req   <= 1'b0;
            out_coeff <= '0;
            sent      <= 1'b0;
        end else begin
            sent <= 1'b0;
            case (state)
                st_idle: begin
                    if (done) begin
                        idx   <= '0;
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    // latched here so it stays put while req is up
                    out_coeff <= rd_coeff;
                    out_req   <= 1'b1;
                    state     <= st_wait_ack;
                end
                st_wait_ack: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= st_wait_release;
                    end
                end
                st_wait_release: begin
                    if (!out_ack) begin
                        if (idx == last_idx) begin
                            sent  <= 1'b1;
                            state <= st_idle;
                        end else begin
                            idx   <= idx + 7'd1;
                            state <= st_fetch;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* source/ntt_engine.sv */
`timescale 1ns/100ps

module ntt_engine
    import ntt_pkg::*;
#(
    parameter int LANES = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  load_beat_t load_beat,
    input  logic       load_valid,
    input  logic       block_loaded,
    output logic       done,
    input  coeff_idx_t rd_idx,
    output coeff_t     rd_coeff
);

    localparam int         issues_per_stage = n_coeff / 2 / LANES;
    localparam logic [5:0] last_issue       = 6'(issues_per_stage - 1);
    localparam logic [2:0] last_stage       = 3'(n_stages - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_drain
    } state_t;

    state_t     state;
    logic [2:0] stage;
    logic [5:0] issue_cnt;
    logic       drain_cnt;
    logic       issuing;

    logic [6:0] span;
    logic [5:0] low_mask;

    coeff_t bank [n_coeff];

    coeff_idx_t up_sel    [LANES];
    coeff_idx_t lo_sel    [LANES];
    coeff_idx_t tw_sel    [LANES];
    lane_pair_t op_q      [LANES];
    coeff_idx_t op_up_idx [LANES];
    coeff_idx_t op_lo_idx [LANES];
    coeff_t     bf_upper  [LANES];
    coeff_t     bf_lower  [LANES];
    coeff_t     res_upper [LANES];
    coeff_t     res_lower [LANES];
    coeff_idx_t wr_up_idx [LANES];
    coeff_idx_t wr_lo_idx [LANES];
    logic       op_valid;
    logic       res_valid;

    // ------------------------------------------------------------------
    // stage and group sequencer
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            stage     <= '0;
            issue_cnt <= '0;
            drain_cnt <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (block_loaded) begin
                        stage     <= '0;
                        issue_cnt <= '0;
                        state     <= st_issue;
                    end
                end
                st_issue: begin
                    if (issue_cnt == last_issue) begin
                        issue_cnt <= '0;
                        drain_cnt <= 1'b0;
                        state     <= st_drain;
                    end else begin
                        issue_cnt <= issue_cnt + 6'd1;
                    end
                end
                st_drain: begin
                    // two cycles so the last write-back lands first
                    drain_cnt <= 1'b1;
                    if (drain_cnt) begin
                        if (stage == last_stage) begin
                            done  <= 1'b1;
                            state <= st_idle;
                        end else begin
                            stage <= stage + 3'd1;
                            state <= st_issue;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign issuing = (state == st_issue);

    // span 64 >> stage, mask of the offset bits inside a block
    assign span     = 7'(n_coeff / 2) >> stage;
    assign low_mask = span[5:0] - 6'd1;

    // ------------------------------------------------------------------
    // lane addressing and butterflies
    // ------------------------------------------------------------------
    for (genvar l = 0; l < LANES; l++) begin : g_lane
        logic [5:0] bfly;

        // butterfly number within the stage
        assign bfly      = 6'(issue_cnt * LANES + l);
        // j = bfly + block * span
        assign up_sel[l] = coeff_idx_t'(bfly) + coeff_idx_t'(bfly & ~low_mask);
        assign lo_sel[l] = up_sel[l] + span;
        // twiddle entry 2^stage + block
        assign tw_sel[l] = (7'd1 << stage) + coeff_idx_t'(bfly >> (last_stage - stage));

        butterfly_unit bfly_i (
            .operands  (op_q[l]),
            .upper_out (bf_upper[l]),
            .lower_out (bf_lower[l])
        );
    end

    // operand and result register levels
    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            if (issuing) begin
                op_q[l].upper   <= bank[up_sel[l]];
                op_q[l].lower   <= bank[lo_sel[l]];
                op_q[l].twiddle <= twiddle_table[tw_sel[l]];
                op_up_idx[l]    <= up_sel[l];
                op_lo_idx[l]    <= lo_sel[l];
            end
            res_upper[l] <= bf_upper[l];
            res_lower[l] <= bf_lower[l];
            wr_up_idx[l] <= op_up_idx[l];
            wr_lo_idx[l] <= op_lo_idx[l];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            op_valid  <= issuing;
            res_valid <= op_valid;
        end
    end

    // ------------------------------------------------------------------
    // coefficient bank
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (load_valid) begin
            for (int i = 0; i < nibbles_per_word; i++) begin
                bank[{load_beat.word_idx, 3'(i)}] <= load_beat.coeff[i];
            end
        end else if (res_valid) begin
            // in place, results go back to the pair they came from
            for (int l = 0; l < LANES; l++) begin
                bank[wr_up_idx[l]] <= res_upper[l];
                bank[wr_lo_idx[l]] <= res_lower[l];
            end
        end
    end

    assign rd_coeff = bank[rd_idx];

endmodule

/* source/ntt_pkg.sv */
package ntt_pkg;

    // ------------------------------------------------------------------
    // field and block constants
    // ------------------------------------------------------------------
    localparam logic [13:0] q_mod     = 14'd12289;
    // -q^-1 mod 2^16 for the montgomery reduction
    localparam logic [13:0] q_neg_inv = 14'd12287;

    localparam int n_coeff          = 128;
    localparam int n_stages         = 7;
    localparam int nibble_width     = 4;
    localparam int nibbles_per_word = 8;
    localparam int words_per_block  = 16;

    // ------------------------------------------------------------------
    // basic types
    // ------------------------------------------------------------------
    typedef logic [15:0] coeff_t;
    typedef logic [13:0] twiddle_t;
    typedef logic [31:0] data_word_t;
    typedef logic [6:0]  coeff_idx_t;

    // one captured input word, already unpacked
    typedef struct packed {
        coeff_t [nibbles_per_word-1:0] coeff;
        logic [3:0]                    word_idx;
    } load_beat_t;

    // operands of one butterfly lane
    typedef struct packed {
        coeff_t   upper;
        coeff_t   lower;
        twiddle_t twiddle;
    } lane_pair_t;

    // ------------------------------------------------------------------
    // twiddles in montgomery form, bit-reversed order
    // ------------------------------------------------------------------
    // entry 0 never addressed
    localparam twiddle_t twiddle_table [n_coeff] = '{
        0,     7888,  11060, 11208, 6960,  4342,  6275,  9759,
        1591,  6399,  9477,  5266,  586,   5825,  7538,  9710,
        1134,  6407,  1711,  965,   7099,  7674,  3743,  6442,
        10414, 8100,  1885,  1688,  1364,  10329, 10164, 9180,
        12210, 6240,  997,   117,   4783,  4407,  1549,  7072,
        2829,  6458,  4431,  8877,  7144,  2564,  5664,  4042,
        12189, 432,   10751, 1237,  7610,  1534,  3983,  7863,
        2181,  6308,  8720,  6570,  4843,  1690,  14,    3872,
        5569,  9368,  12163, 2019,  7543,  2315,  4673,  7340,
        1553,  1156,  8401,  11389, 1020,  2967,  10772, 7045,
        3316,  11236, 5285,  11578, 10637, 10086, 9493,  6180,
        9277,  6130,  3323,  883,   10469, 489,   1502,  2851,
        11061, 9729,  2742,  12241, 4970,  10481, 10078, 1195,
        730,   1762,  3854,  2030,  5892,  10922, 9020,  5274,
        9179,  3604,  3782,  10206, 3180,  3467,  4668,  2446,
        7613,  9386,  834,   7703,  6836,  3403,  5351,  12276
    };

endpackage

/* source/ntt_top.sv */
`timescale 1ns/100ps

module ntt_top
    import ntt_pkg::*;
#(
    parameter int LANES = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_req,
    input  data_word_t in_word,
    output logic       in_ack,
    output logic       out_req,
    output coeff_t     out_coeff,
    input  logic       out_ack
);

    load_beat_t load_beat;
    logic       load_valid;
    logic       block_loaded;
    logic       done;
    logic       sent;
    coeff_idx_t rd_idx;
    coeff_t     rd_coeff;

    // ------------------------------------------------------------------
    // input side, transform, output side
    // ------------------------------------------------------------------
    word_collector collector_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_req       (in_req),
        .in_word      (in_word),
        .in_ack       (in_ack),
        .sent         (sent),
        .load_beat    (load_beat),
        .load_valid   (load_valid),
        .block_loaded (block_loaded)
    );

    ntt_engine #(
        .LANES (LANES)
    ) engine_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_beat    (load_beat),
        .load_valid   (load_valid),
        .block_loaded (block_loaded),
        .done         (done),
        .rd_idx       (rd_idx),
        .rd_coeff     (rd_coeff)
    );

    coefficient_sender sender_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .done      (done),
        .rd_idx    (rd_idx),
        .rd_coeff  (rd_coeff),
        .out_req   (out_req),
        .out_coeff (out_coeff),
        .out_ack   (out_ack),
        .sent      (sent)
    );

endmodule

/* source/word_collector.sv */
`timescale 1ns/100ps

module word_collector
    import ntt_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_req,
    input  data_word_t in_word,
    output logic       in_ack,
    input  logic       sent,
    output load_beat_t load_beat,
    output logic       load_valid,
    output logic       block_loaded
);

    localparam logic [3:0] last_word = 4'(words_per_block - 1);

    logic [3:0] word_cnt;
    logic       held;
    logic       capture;

    // new word: req up, ack still down, no block in flight
    assign capture = in_req && !in_ack && !held;

    // ------------------------------------------------------------------
    // four-phase receiver
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ack       <= 1'b0;
            load_valid   <= 1'b0;
            block_loaded <= 1'b0;
            word_cnt     <= '0;
            held         <= 1'b0;
        end else begin
            load_valid   <= capture;
            block_loaded <= capture && (word_cnt == last_word);

            // output side finished, next block may come in
            if (sent) begin
                held <= 1'b0;
            end

            if (capture) begin
                in_ack   <= 1'b1;
                word_cnt <= word_cnt + 4'd1;
                if (word_cnt == last_word) begin
                    held <= 1'b1;
                end
            end else if (in_ack && !in_req) begin
                in_ack <= 1'b0;
            end
        end
    end

    // unpack nibbles, nibble i becomes coefficient i of the word
    always_ff @(posedge clk) begin
        if (capture) begin
            load_beat.word_idx <= word_cnt;
            for (int i = 0; i < nibbles_per_word; i++) begin
                load_beat.coeff[i] <= coeff_t'(in_word[i*nibble_width +: nibble_width]);
            end
        end
    end

endmodule

/* verification/ntt_checker.sv */
`timescale 1ns/100ps

module ntt_checker
    import ntt_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input logic   in_req,
    input logic   in_ack,
    input logic   out_req,
    input coeff_t out_coeff,
    input logic   out_ack
);

    int violation_count = 0;

    // ------------------------------------------------------------------
    // handshake protocol
    // ------------------------------------------------------------------
    ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(in_ack) |-> in_req
    ) else begin
        violation_count++;
        $error("in_ack rose while in_req was low");
    end

    // held for the whole transfer
    coeff_stable: assert property (
        @(posedge clk) disable iff (!rst_n) (out_req && $past(out_req)) |-> $stable(out_coeff)
    ) else begin
        violation_count++;
        $error("out_coeff changed while out_req was high");
    end

    req_waits_ack: assert property (
        @(posedge clk) disable iff (!rst_n) (out_req && !out_ack) |=> out_req
    ) else begin
        violation_count++;
        $error("out_req fell before out_ack rose");
    end

    coeff_in_field: assert property (
        @(posedge clk) disable iff (!rst_n) out_coeff < coeff_t'(q_mod)
    ) else begin
        violation_count++;
        $error("out_coeff %0d not below the field prime", out_coeff);
    end

endmodule

bind ntt_top ntt_checker protocol_check_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_req    (in_req),
    .in_ack    (in_ack),
    .out_req   (out_req),
    .out_coeff (out_coeff),
    .out_ack   (out_ack)
);

/* verification/ntt_model.svh */
`ifndef NTT_MODEL_SVH
`define NTT_MODEL_SVH

// ------------------------------------------------------------------
// reference transform, works in place on ref_coeff
// ------------------------------------------------------------------
localparam longint ref_q  = longint'(q_mod);
localparam longint mont_r = 64'd1 << 16;

int ref_coeff [n_coeff];

// square and multiply, used for the inverse of R via Fermat
function automatic longint mod_pow(input longint base, input longint expo);
    longint result;
    longint b;
    longint e;
    result = 1;
    b      = base % ref_q;
    e      = expo;
    while (e > 0) begin
        if (e[0]) begin
            result = (result * b) % ref_q;
        end
        b = (b * b) % ref_q;
        e = e >> 1;
    end
    return result;
endfunction

// a * w * R^-1 mod q
function automatic longint mont_mul(input longint a, input longint w);
    longint r_inv;
    r_inv = mod_pow(mont_r % ref_q, ref_q - 2);
    return (((a * w) % ref_q) * r_inv) % ref_q;
endfunction

task automatic run_reference_ntt();
    int     span;
    int     base;
    longint tw;
    longint t;
    for (int s = 0; s < n_stages; s++) begin
        span = (n_coeff / 2) >> s;
        for (int k = 0; k < (1 << s); k++) begin
            tw   = twiddle_table[(1 << s) + k];
            base = k * 2 * span;
            for (int j = base; j < base + span; j++) begin
                t = mont_mul(ref_coeff[j + span], tw);
                ref_coeff[j + span] = int'((ref_coeff[j] - t + ref_q) % ref_q);
                ref_coeff[j]        = int'((ref_coeff[j] + t) % ref_q);
            end
        end
    end
endtask

`endif

/* verification/ntt_tb.sv */
`timescale 1ns/100ps

module ntt_tb
    import ntt_pkg::*;
();

    localparam int n_blocks       = 5;
    localparam int timeout_cycles = 6 * 1200;

    logic       clk;
    logic       rst_n;
    logic       in_req;
    data_word_t in_word;
    logic       in_ack;
    logic       out_req;
    coeff_t     out_coeff;
    logic       out_ack;

    logic [31:0] data_rng;
    logic [31:0] delay_rng;
    int          cycle_cnt      = 0;
    int          words_acked    = 0;
    int          words_released = 0;
    int          blocks_done    = 0;
    coeff_t      expect_q [$];
    string       name_q [$];
    data_word_t  block_words [words_per_block];

    `include "ntt_model.svh"

    ntt_top #(
        .LANES (8)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_req    (in_req),
        .in_word   (in_word),
        .in_ack    (in_ack),
        .out_req   (out_req),
        .out_coeff (out_coeff),
        .out_ack   (out_ack)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("run timed out after %0d cycles", cycle_cnt);
            $display("=== FAIL ===");
            $fatal(1);
        end else if (dut_i.protocol_check_i.violation_count != 0) begin
            $display("protocol checker reported a violation");
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic random_wait();
        delay_rng = xorshift32(delay_rng);
        repeat (delay_rng[1:0]) @(posedge clk);
    endtask

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic send_word(input data_word_t word);
        in_req  <= 1'b1;
        in_word <= word;
        @(posedge clk);
        while (!in_ack) @(posedge clk);
        // words of block n only once block n-1 has left
        assert (words_acked / words_per_block <= blocks_done)
            else stop_on_error($sformatf("word %0d acknowledged before %0d blocks were sent",
                                         words_acked, words_acked / words_per_block));
        words_acked++;
        in_req <= 1'b0;
        @(posedge clk);
        while (in_ack) @(posedge clk);
        words_released++;
    endtask

    task automatic send_block(input string name);
        for (int w = 0; w < words_per_block; w++) begin
            for (int i = 0; i < nibbles_per_word; i++) begin
                ref_coeff[w * nibbles_per_word + i] = block_words[w][i*nibble_width +: nibble_width];
            end
        end
        run_reference_ntt();
        for (int k = 0; k < n_coeff; k++) begin
            expect_q.push_back(coeff_t'(ref_coeff[k]));
        end
        name_q.push_back(name);
        for (int w = 0; w < words_per_block; w++) begin
            send_word(block_words[w]);
        end
    endtask

    // ------------------------------------------------------------------
    // output side partner
    // ------------------------------------------------------------------
    initial begin : receive_proc
        coeff_t got;
        forever begin
            for (int i = 0; i < n_coeff; i++) begin
                @(posedge clk);
                while (!out_req) @(posedge clk);
                got = out_coeff;
                // output of a block starts only after its last word is released
                if (i == 0) begin
                    assert (words_released >= (blocks_done + 1) * words_per_block)
                        else stop_on_error("first coefficient came before the last input word");
                end
                assert (expect_q.size() > 0)
                    else stop_on_error("coefficient arrived with no block outstanding");
                assert (got == expect_q[0])
                    else stop_on_error($sformatf("[FAIL] %s coeff %0d expected %0d actual %0d",
                                                 name_q[0], i, expect_q[0], got));
                void'(expect_q.pop_front());
                random_wait();
                out_ack <= 1'b1;
                if (i == n_coeff - 1) begin
                    void'(name_q.pop_front());
                    blocks_done++;
                end
                @(posedge clk);
                while (out_req) @(posedge clk);
                random_wait();
                out_ack <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------
    // main sequence with blocks going in back to back
    // ------------------------------------------------------------------
    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_req    = 1'b0;
        in_word   = '0;
        out_ack   = 1'b0;
        data_rng  = 32'd15;
        delay_rng = 32'd15;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        for (int w = 0; w < words_per_block; w++) begin
            block_words[w] = '0;
        end
        send_block("zero_block");

        // only coefficient 0 set so every output equals it
        block_words[0] = 32'h0000_0009;
        send_block("impulse_block");

        for (int b = 0; b < 3; b++) begin
            for (int w = 0; w < words_per_block; w++) begin
                data_rng       = xorshift32(data_rng);
                block_words[w] = data_rng;
            end
            send_block($sformatf("random_block_%0d", b));
        end

        while (blocks_done < n_blocks) @(posedge clk);
        repeat (10) @(posedge clk);
        if (dut_i.protocol_check_i.violation_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("protocol checker reported %0d violations",
                     dut_i.protocol_check_i.violation_count);
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

endmodule
